// File: tcp_tx_pkg.sv
`default_nettype none

package tcp_tx_pkg;

  // plain widths
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] port_t;
  typedef logic [31:0] seq_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] chsum_t;
  typedef logic [31:0] chsum_acc_t; // unfolded ones-complement sum
  typedef logic [15:0] len_t;

  // fixed header fields, offset and checksum are filled in by the engine
  typedef struct packed {
    port_t      src_port;
    port_t      dst_port;
    seq_t       seq_num;
    seq_t       ack_num;
    logic [8:0] flags;    // ns..fin
    logic [15:0] win_size;
    logic [15:0] urg_ptr;
  } tcp_hdr_t;

  typedef struct packed {
    seq_t left;
    seq_t right;
  } sack_block_t;

  // connection-wide option settings
  typedef struct packed {
    logic [15:0] mss;
    logic [7:0]  win_shift;
    logic        mss_en;
    logic        win_en;
    logic        sack_perm_en;
    logic        ts_en;
  } tcp_opt_cfg_t;

  // options that change per segment
  typedef struct packed {
    logic              sack_pres;
    logic [3:0]        block_pres;
    sack_block_t [3:0] sack;
    logic [31:0]       ts_val;
    logic [31:0]       ts_ecr;
  } tcp_opt_pkt_t;

  typedef struct packed {
    tcp_hdr_t   hdr;
    ipv4_addr_t src_ip;
    ipv4_addr_t dst_ip;
    len_t       payload_len;
    chsum_acc_t payload_chsum; // partial sum from the caller
  } tcp_seg_t;

  typedef byte_t [0:39] opt_field_t; // byte 0 goes out first
  typedef logic [3:0]   opt_words_t;

  localparam opt_words_t OPT_MAX_WORDS = 4'd10;
  localparam int         HDR_MAX_BYTES = 60;

  // option kinds
  localparam byte_t TCP_OPT_NOP       = 8'd1;
  localparam byte_t TCP_OPT_MSS       = 8'd2;
  localparam byte_t TCP_OPT_WIN       = 8'd3;
  localparam byte_t TCP_OPT_SACK_PERM = 8'd4;
  localparam byte_t TCP_OPT_SACK      = 8'd5;
  localparam byte_t TCP_OPT_TIMESTAMP = 8'd8;

  localparam byte_t IP_PROTO_TCP = 8'd6;

endpackage

`default_nettype wire

// File: tcp_tx_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_cfg (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  logic                     cfg_we,
  input  logic [1:0]               cfg_addr,
  input  logic [15:0]              cfg_data,
  output tcp_tx_pkg::tcp_opt_cfg_t cfg
);

  import tcp_tx_pkg::*;

  localparam logic [15:0] MSS_DEFAULT = 16'd1460;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cfg.mss          <= MSS_DEFAULT;
      cfg.win_shift    <= '0;
      cfg.mss_en       <= 1'b0;
      cfg.win_en       <= 1'b0;
      cfg.sack_perm_en <= 1'b0;
      cfg.ts_en        <= 1'b0;
    end else if (cfg_we) begin
      case (cfg_addr)
        2'd0: cfg.mss <= cfg_data;
        2'd1: cfg.win_shift <= cfg_data[7:0];
        2'd2: begin
          // bit 0 mss, 1 window scale, 2 sack-permitted, 3 timestamp
          cfg.mss_en       <= cfg_data[0];
          cfg.win_en       <= cfg_data[1];
          cfg.sack_perm_en <= cfg_data[2];
          cfg.ts_en        <= cfg_data[3];
        end
        default: ; // address 3 is unused
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tcp_opt_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_opt_assembler (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  logic                     seg_v,
  input  tcp_tx_pkg::tcp_opt_pkt_t opt_pkt,
  input  tcp_tx_pkg::tcp_opt_cfg_t cfg,
  output tcp_tx_pkg::opt_field_t   opt_field,
  output tcp_tx_pkg::opt_words_t   opt_words,
  output logic                     opt_done
);

  import tcp_tx_pkg::*;

  logic [0:14][31:0] proto; // every possible option word
  logic [0:14]       pres;
  logic [2:0]        n_blocks;
  byte_t             sack_len;

  logic [0:13][31:0] word_q; // words 1..14 waiting to be placed
  logic [0:13]       pres_q;
  logic [3:0]        step;
  logic              run;

  assign n_blocks = 3'(opt_pkt.block_pres[0]) + 3'(opt_pkt.block_pres[1]) +
                    3'(opt_pkt.block_pres[2]) + 3'(opt_pkt.block_pres[3]);
  assign sack_len = byte_t'({n_blocks, 3'b000}) + 8'd2; // 8n+2

  assign proto = {
    {TCP_OPT_MSS, 8'd4, cfg.mss},
    {TCP_OPT_NOP, TCP_OPT_WIN, 8'd3, cfg.win_shift},
    {TCP_OPT_NOP, TCP_OPT_NOP, TCP_OPT_SACK_PERM, 8'd2},
    {TCP_OPT_NOP, TCP_OPT_NOP, TCP_OPT_SACK, sack_len},
    opt_pkt.sack[0].left, opt_pkt.sack[0].right,
    opt_pkt.sack[1].left, opt_pkt.sack[1].right,
    opt_pkt.sack[2].left, opt_pkt.sack[2].right,
    opt_pkt.sack[3].left, opt_pkt.sack[3].right,
    {TCP_OPT_NOP, TCP_OPT_NOP, TCP_OPT_TIMESTAMP, 8'd10},
    opt_pkt.ts_val,
    opt_pkt.ts_ecr
  };

  assign pres = {
    cfg.mss_en, cfg.win_en, cfg.sack_perm_en, opt_pkt.sack_pres,
    {2{opt_pkt.sack_pres & opt_pkt.block_pres[0]}},
    {2{opt_pkt.sack_pres & opt_pkt.block_pres[1]}},
    {2{opt_pkt.sack_pres & opt_pkt.block_pres[2]}},
    {2{opt_pkt.sack_pres & opt_pkt.block_pres[3]}},
    {3{cfg.ts_en}}
  };

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      run       <= 1'b0;
      step      <= '0;
      opt_words <= '0;
      opt_done  <= 1'b0;
    end else begin
      opt_done <= 1'b0;
      if (seg_v) begin
        run       <= 1'b1;
        step      <= '0;
        opt_words <= opt_words_t'(pres[0]); // word 0 is placed right away
      end else if (run) begin
        step <= step + 4'd1;
        // words past 40 bytes are dropped
        if (pres_q[0] && opt_words != OPT_MAX_WORDS) opt_words <= opt_words + 4'd1;
        if (step == 4'd13) begin
          run      <= 1'b0;
          opt_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (seg_v) begin
      word_q    <= proto[1:14];
      pres_q    <= pres[1:14];
      opt_field <= '0;
      if (pres[0]) opt_field[0:3] <= proto[0];
    end else if (run) begin
      word_q <= {word_q[1:13], 32'h0};
      pres_q <= {pres_q[1:13], 1'b0};
      if (pres_q[0] && opt_words != OPT_MAX_WORDS) begin
        opt_field[{opt_words, 2'b00} +: 4] <= word_q[0]; // next free slot
      end
    end
  end

  a_opt_words_max: assert property (@(posedge clk) disable iff (fsm_rst)
    opt_done |-> opt_words <= OPT_MAX_WORDS);

endmodule

`default_nettype wire

// File: tcp_chsum_calc.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_chsum_calc (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   start,
  input  tcp_tx_pkg::tcp_seg_t   seg,
  input  tcp_tx_pkg::opt_field_t opt_field,
  input  tcp_tx_pkg::opt_words_t opt_words,
  output tcp_tx_pkg::chsum_t     chsum,
  output logic                   chsum_done
);

  import tcp_tx_pkg::*;

  typedef enum logic [1:0] {cs_idle, cs_add, cs_fold} cs_state_t;

  cs_state_t         state;
  logic [4:0]        hdr_words; // header length in 32-bit words
  len_t              tcp_len;
  logic [0:35][15:0] words;     // pseudo header then tcp header
  logic [0:34][15:0] word_sr;
  chsum_acc_t        acc;
  logic [5:0]        left_cnt;
  logic [16:0]       fold_sum;

  assign hdr_words = 5'd5 + 5'(opt_words);
  assign tcp_len   = len_t'({hdr_words, 2'b00}) + seg.payload_len;

  assign words = {
    seg.src_ip, seg.dst_ip, 8'h00, IP_PROTO_TCP, tcp_len,
    seg.hdr.src_port, seg.hdr.dst_port, seg.hdr.seq_num, seg.hdr.ack_num,
    hdr_words[3:0], 3'b000, seg.hdr.flags, seg.hdr.win_size,
    16'h0000, // checksum field counts as zero
    seg.hdr.urg_ptr,
    opt_field
  };

  assign fold_sum = {1'b0, acc[31:16]} + {1'b0, acc[15:0]};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state      <= cs_idle;
      chsum_done <= 1'b0;
      left_cnt   <= '0;
    end else begin
      chsum_done <= 1'b0;
      case (state)
        cs_idle: if (start) begin
          state    <= cs_add;
          left_cnt <= 6'({hdr_words, 1'b0}) + 6'd5; // first word goes in at start
        end
        cs_add: begin
          left_cnt <= left_cnt - 6'd1;
          if (left_cnt == 6'd1) state <= cs_fold;
        end
        cs_fold: begin
          state      <= cs_idle;
          chsum_done <= 1'b1;
        end
        default: state <= cs_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cs_idle && start) begin
      acc     <= seg.payload_chsum + chsum_acc_t'(words[0]);
      word_sr <= words[1:35];
    end else if (state == cs_add) begin
      acc     <= acc + chsum_acc_t'(word_sr[0]);
      word_sr <= {word_sr[1:34], 16'h0};
    end
    if (state == cs_fold) chsum <= ~(fold_sum[15:0] + 16'(fold_sum[16]));
  end

  // opt_done only comes once per accepted segment
  a_start_idle: assert property (@(posedge clk) disable iff (fsm_rst)
    start |-> state == cs_idle);

endmodule

`default_nettype wire

// File: tcp_hdr_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_hdr_serializer #(
  parameter int RAM_ADDR_W = 10
) (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   seg_v,
  input  tcp_tx_pkg::tcp_seg_t   seg,
  input  tcp_tx_pkg::opt_field_t opt_field,
  input  tcp_tx_pkg::opt_words_t opt_words,
  input  logic                   chsum_done,
  input  tcp_tx_pkg::chsum_t     chsum,
  input  tcp_tx_pkg::byte_t      ram_q,
  output logic                   seg_start, // seg_v taken while idle
  output tcp_tx_pkg::tcp_seg_t   seg_hold,
  output logic [RAM_ADDR_W-1:0]  ram_raddr,
  output tcp_tx_pkg::byte_t      tx_d,
  output logic                   tx_v,
  output logic                   tx_sof,
  output logic                   tx_eof,
  output logic                   busy
);

  import tcp_tx_pkg::*;

  typedef enum logic [1:0] {idle, wait_chsum, header, payload} ser_state_t;

  ser_state_t                   state;
  logic [0:HDR_MAX_BYTES-1][7:0] hdr_sr;
  logic [0:HDR_MAX_BYTES-1][7:0] hdr_full;
  logic [3:0]                   hdr_off;
  logic [5:0]                   hdr_last; // index of last header byte
  len_t                         cnt;
  logic                         hdr_end;
  logic                         pay_end;

  assign hdr_off = 4'd5 + opt_words;

  assign hdr_full = {
    seg_hold.hdr.src_port, seg_hold.hdr.dst_port,
    seg_hold.hdr.seq_num, seg_hold.hdr.ack_num,
    hdr_off, 3'b000, seg_hold.hdr.flags,
    seg_hold.hdr.win_size, chsum, seg_hold.hdr.urg_ptr,
    opt_field
  };

  assign hdr_end = (cnt == len_t'(hdr_last));
  assign pay_end = (cnt == seg_hold.payload_len - len_t'(1));

  assign seg_start = seg_v && (state == idle);
  assign busy      = (state != idle);
  assign tx_v      = (state == header) || (state == payload);
  assign tx_sof    = (state == header) && (cnt == '0);
  assign tx_eof    = ((state == header) && hdr_end && (seg_hold.payload_len == '0)) ||
                     ((state == payload) && pay_end);
  assign tx_d      = (state == payload) ? ram_q : hdr_sr[0];

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= idle;
      cnt       <= '0;
      ram_raddr <= '0;
    end else begin
      case (state)
        idle: if (seg_v) state <= wait_chsum;
        wait_chsum: if (chsum_done) begin
          state     <= header;
          cnt       <= '0;
          ram_raddr <= seg_hold.hdr.seq_num[RAM_ADDR_W-1:0];
        end
        header: begin
          if (hdr_end) begin
            cnt <= '0;
            if (seg_hold.payload_len == '0) begin
              state <= idle;
            end else begin
              state     <= payload;
              ram_raddr <= ram_raddr + 1'b1; // read runs one byte ahead
            end
          end else begin
            cnt <= cnt + len_t'(1);
          end
        end
        payload: begin
          ram_raddr <= ram_raddr + 1'b1;
          if (pay_end) begin
            state <= idle;
            cnt   <= '0;
          end else begin
            cnt <= cnt + len_t'(1);
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (seg_start) seg_hold <= seg;
    if (state == wait_chsum && chsum_done) begin
      hdr_sr   <= hdr_full;
      hdr_last <= {hdr_off, 2'b00} - 6'd1;
    end else if (state == header) begin
      hdr_sr <= {hdr_sr[1:HDR_MAX_BYTES-1], 8'h00};
    end
  end

  // header goes out right after the checksum lands
  a_sof_after_chsum: assert property (@(posedge clk) disable iff (fsm_rst)
    chsum_done |=> tx_sof && tx_v);

  a_seg_busy: assert property (@(posedge clk) disable iff (fsm_rst)
    busy |-> !seg_v) else $warning("seg_v while busy, segment dropped");

endmodule

`default_nettype wire

// File: tcp_payload_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_payload_ram #(
  parameter int RAM_ADDR_W = 10
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic [RAM_ADDR_W-1:0] waddr,
  input  tcp_tx_pkg::byte_t     wdata,
  input  logic [RAM_ADDR_W-1:0] raddr,
  output tcp_tx_pkg::byte_t     q
);

  import tcp_tx_pkg::*;

  byte_t mem [2**RAM_ADDR_W]; // transmit queue, one byte per sequence number

  always_ff @(posedge clk) begin
    if (we) mem[waddr] <= wdata;
    q <= mem[raddr]; // one cycle read latency
  end

endmodule

`default_nettype wire

// File: tcp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_top #(
  parameter int RAM_ADDR_W = 10
) (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  logic                     seg_v,
  input  tcp_tx_pkg::tcp_seg_t     seg,
  input  tcp_tx_pkg::tcp_opt_pkt_t opt_pkt,
  input  logic                     cfg_we,
  input  logic [1:0]               cfg_addr,
  input  logic [15:0]              cfg_data,
  input  logic                     ram_we,
  input  logic [RAM_ADDR_W-1:0]    ram_addr,
  input  tcp_tx_pkg::byte_t        ram_data,
  output tcp_tx_pkg::byte_t        tx_d,
  output logic                     tx_v,
  output logic                     tx_sof,
  output logic                     tx_eof,
  output logic                     busy
);

  import tcp_tx_pkg::*;

  tcp_opt_cfg_t          cfg;
  opt_field_t            opt_field;
  opt_words_t            opt_words;
  logic                  opt_done;
  chsum_t                chsum;
  logic                  chsum_done;
  logic                  seg_start;
  tcp_seg_t              seg_hold;
  logic [RAM_ADDR_W-1:0] ram_raddr;
  byte_t                 ram_q;

  tcp_tx_cfg cfg_i (
    .clk, .fsm_rst, .cfg_we, .cfg_addr, .cfg_data, .cfg
  );

  tcp_opt_assembler opt_i (
    .clk, .fsm_rst, .seg_v(seg_start), .opt_pkt, .cfg,
    .opt_field, .opt_words, .opt_done
  );

  tcp_chsum_calc chsum_i (
    .clk, .fsm_rst, .start(opt_done), .seg(seg_hold), .opt_field, .opt_words,
    .chsum, .chsum_done
  );

  tcp_hdr_serializer #(.RAM_ADDR_W(RAM_ADDR_W)) ser_i (
    .clk, .fsm_rst, .seg_v, .seg, .opt_field, .opt_words, .chsum_done, .chsum,
    .ram_q, .seg_start, .seg_hold, .ram_raddr, .tx_d, .tx_v, .tx_sof, .tx_eof, .busy
  );

  tcp_payload_ram #(.RAM_ADDR_W(RAM_ADDR_W)) ram_i (
    .clk, .we(ram_we), .waddr(ram_addr), .wdata(ram_data), .raddr(ram_raddr), .q(ram_q)
  );

endmodule

`default_nettype wire

// File: tb_tcp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tcp_tx;

  import tcp_tx_pkg::*;

  localparam int RAM_ADDR_W = 10;
  localparam int RAM_DEPTH  = 2**RAM_ADDR_W;
  localparam int N_ROWS     = 8;
  localparam int MAX_PAY    = 48;
  localparam int ROW_CYCLES = 160 + MAX_PAY; // longest header path plus payload
  localparam int WD_CYCLES  = RAM_DEPTH + 16 + N_ROWS * ROW_CYCLES;
  localparam logic [31:0] SEED = 32'h327d_3eae;

  typedef struct packed {
    logic [15:0] mss;
    logic [7:0]  win_shift;
    logic [3:0]  en;          // ts, sack-perm, win, mss
    tcp_hdr_t    hdr;
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
    logic        sack_pres;
    logic [3:0]  block_pres;
    len_t        payload_len;
    logic        b2b;         // seg_v in the cycle right after the previous eof
    logic        spur;        // extra seg_v while busy
    logic        mid_rst;     // fsm_rst during the header
  } row_t;

  logic                  clk;
  logic                  fsm_rst;
  logic                  seg_v;
  tcp_seg_t              seg;
  tcp_opt_pkt_t          opt_pkt;
  logic                  cfg_we;
  logic [1:0]            cfg_addr;
  logic [15:0]           cfg_data;
  logic                  ram_we;
  logic [RAM_ADDR_W-1:0] ram_addr;
  byte_t                 ram_data;
  byte_t                 tx_d;
  logic                  tx_v;
  logic                  tx_sof;
  logic                  tx_eof;
  logic                  busy;

  row_t         rows [N_ROWS];
  tcp_opt_pkt_t pkts [N_ROWS];   // random sack and timestamp values per row
  byte_t        shadow [RAM_DEPTH];
  byte_t        exp_q [$];
  chsum_t       exp_chsum;
  int           byte_errs;
  int           chsum_errs;
  int           flag_errs;

  tcp_tx_top #(.RAM_ADDR_W(RAM_ADDR_W)) dut_i (
    .clk, .fsm_rst, .seg_v, .seg, .opt_pkt, .cfg_we, .cfg_addr, .cfg_data,
    .ram_we, .ram_addr, .ram_data, .tx_d, .tx_v, .tx_sof, .tx_eof, .busy
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped producing output", WD_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      byte_errs++;
      $display("[FAIL] %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_chsum(input chsum_t got, input chsum_t exp, input int r);
    if (got !== exp) begin
      chsum_errs++;
      $display("[FAIL] %0t: row %0d checksum got %04h expected %04h", $time, r, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // columns: mss, shift, en, header, src ip, dst ip, sack, blocks, len, b2b, spur, rst
  task automatic load_table();
    rows[0] = '{16'd1460, 8'd0, 4'b0000,
                '{16'd1234, 16'd80, 32'h1000_0010, 32'h0000_0001, 9'h018, 16'd8192, 16'd0},
                32'hc0a8_0001, 32'hc0a8_0002, 1'b0, 4'b0000, 16'd13, 1'b0, 1'b0, 1'b0};
    rows[1] = '{16'd1460, 8'd7, 4'b1111,
                '{16'd4321, 16'd443, 32'h2222_03f8, 32'h1357_9bdf, 9'h010, 16'd65535, 16'd0},
                32'h0a00_0001, 32'h0a00_00fe, 1'b1, 4'b1111, 16'd20, 1'b0, 1'b0, 1'b0};
    rows[2] = '{16'd1460, 8'd0, 4'b1000,
                '{16'd5000, 16'd5001, 32'h3000_0100, 32'hdead_beef, 9'h011, 16'd1024, 16'd0},
                32'hac10_0101, 32'hac10_0202, 1'b1, 4'b0111, 16'd0, 1'b0, 1'b0, 1'b0};
    rows[3] = '{16'd536, 8'd14, 4'b0010,
                '{16'd6000, 16'd22, 32'h4000_0200, 32'h0102_0304, 9'h018, 16'd300, 16'h0000},
                32'hc0a8_0a01, 32'hc0a8_0a02, 1'b0, 4'b0000, 16'd32, 1'b0, 1'b0, 1'b0};
    rows[4] = '{16'd1400, 8'd3, 4'b0101,
                '{16'd7000, 16'd7001, 32'h5000_0280, 32'h7777_0000, 9'h038, 16'd512, 16'h0005},
                32'h0102_0304, 32'h0506_0708, 1'b1, 4'b0001, 16'd48, 1'b1, 1'b1, 1'b0};
    rows[5] = '{16'd1460, 8'd0, 4'b0000,
                '{16'd8000, 16'd8080, 32'h6000_02c0, 32'h0000_ffff, 9'h001, 16'd0, 16'd0},
                32'hffff_fffe, 32'h0000_0001, 1'b0, 4'b0000, 16'd1, 1'b1, 1'b0, 1'b0};
    rows[6] = '{16'd1460, 8'd5, 4'b0111,
                '{16'd9000, 16'd9001, 32'h7000_0300, 32'h1111_2222, 9'h010, 16'd4096, 16'd0},
                32'hc0a8_6401, 32'hc0a8_6402, 1'b1, 4'b0101, 16'd40, 1'b0, 1'b0, 1'b1};
    rows[7] = '{16'd1200, 8'd2, 4'b0011,
                '{16'd1111, 16'd2222, 32'h8000_0340, 32'h3333_4444, 9'h018, 16'd2048, 16'd0},
                32'h0a01_0203, 32'h0a04_0506, 1'b0, 4'b0000, 16'd7, 1'b0, 1'b0, 1'b0};
  endtask

  task automatic make_random();
    for (int a = 0; a < RAM_DEPTH; a++) shadow[a] = 8'($urandom);
    for (int r = 0; r < N_ROWS; r++) begin
      for (int b = 0; b < 4; b++) begin
        pkts[r].sack[b].left  = $urandom;
        pkts[r].sack[b].right = $urandom;
      end
      pkts[r].ts_val     = $urandom;
      pkts[r].ts_ecr     = $urandom;
      pkts[r].sack_pres  = rows[r].sack_pres;
      pkts[r].block_pres = rows[r].block_pres;
    end
  endtask

  function automatic int ram_index(input seq_t seq, input int i);
    seq_t a;
    a = seq + seq_t'(i);
    return int'(a[RAM_ADDR_W-1:0]);
  endfunction

  function automatic logic [31:0] add16(input logic [31:0] s, input logic [15:0] w);
    return s + {16'h0000, w};
  endfunction

  // big-endian byte pairs, odd tail padded with zero
  function automatic logic [31:0] payload_sum(input row_t rw);
    logic [31:0] s;
    byte_t       hi;
    byte_t       lo;
    s = '0;
    for (int i = 0; i < int'(rw.payload_len); i += 2) begin
      hi = shadow[ram_index(rw.hdr.seq_num, i)];
      lo = (i + 1 < int'(rw.payload_len)) ? shadow[ram_index(rw.hdr.seq_num, i + 1)] : 8'h00;
      s  = add16(s, {hi, lo});
    end
    return s;
  endfunction

  task automatic build_expected(input int r);
    row_t             rw;
    tcp_opt_pkt_t     p;
    logic [31:0]      w [$];
    logic [0:19][7:0] base;
    logic [31:0]      sum;
    int               n;
    int               nw;
    int               hlen;
    rw = rows[r];
    p  = pkts[r];
    n  = 0;
    for (int b = 0; b < 4; b++) if (rw.block_pres[b]) n++;
    // prototype order, each word NOP padded
    if (rw.en[0]) w.push_back({8'd2, 8'd4, rw.mss});
    if (rw.en[1]) w.push_back({8'd1, 8'd3, 8'd3, rw.win_shift});
    if (rw.en[2]) w.push_back({8'd1, 8'd1, 8'd4, 8'd2});
    if (rw.sack_pres) begin
      w.push_back({8'd1, 8'd1, 8'd5, 8'(8 * n + 2)});
      for (int b = 0; b < 4; b++) begin
        if (rw.block_pres[b]) begin
          w.push_back(p.sack[b].left);
          w.push_back(p.sack[b].right);
        end
      end
    end
    if (rw.en[3]) begin
      w.push_back({8'd1, 8'd1, 8'd8, 8'd10});
      w.push_back(p.ts_val);
      w.push_back(p.ts_ecr);
    end
    nw   = (w.size() > 10) ? 10 : w.size(); // 40-byte field keeps the first ten words
    hlen = 20 + 4 * nw;
    base = {rw.hdr.src_port, rw.hdr.dst_port, rw.hdr.seq_num, rw.hdr.ack_num,
            4'(5 + nw), 3'b000, rw.hdr.flags, rw.hdr.win_size, 16'h0000, rw.hdr.urg_ptr};
    exp_q.delete();
    for (int i = 0; i < 20; i++) exp_q.push_back(base[i]);
    for (int i = 0; i < nw; i++) begin
      for (int k = 0; k < 4; k++) exp_q.push_back(w[i][31 - 8 * k -: 8]);
    end
    // pseudo header then header, on top of the payload sum
    sum = payload_sum(rw);
    sum = add16(sum, rw.src_ip[31:16]);
    sum = add16(sum, rw.src_ip[15:0]);
    sum = add16(sum, rw.dst_ip[31:16]);
    sum = add16(sum, rw.dst_ip[15:0]);
    sum = add16(sum, 16'h0006);
    sum = add16(sum, 16'(hlen) + rw.payload_len);
    for (int i = 0; i < hlen / 2; i++) sum = add16(sum, {exp_q[2 * i], exp_q[2 * i + 1]});
    while (sum[31:16] != 16'h0000) sum = add16({16'h0000, sum[31:16]}, sum[15:0]);
    exp_chsum = ~sum[15:0];
    exp_q[16] = exp_chsum[15:8];
    exp_q[17] = exp_chsum[7:0];
    for (int i = 0; i < int'(rw.payload_len); i++) begin
      exp_q.push_back(shadow[ram_index(rw.hdr.seq_num, i)]);
    end
  endtask

  task automatic fill_ram();
    for (int a = 0; a < RAM_DEPTH; a++) begin
      @(posedge clk);
      ram_we   <= 1'b1;
      ram_addr <= RAM_ADDR_W'(a);
      ram_data <= shadow[a];
    end
    @(posedge clk);
    ram_we <= 1'b0;
  endtask

  task automatic write_cfg_reg(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk);
    cfg_we   <= 1'b1;
    cfg_addr <= addr;
    cfg_data <= data;
  endtask

  task automatic write_cfg(input int r);
    write_cfg_reg(2'd0, rows[r].mss);
    write_cfg_reg(2'd1, {8'h00, rows[r].win_shift});
    write_cfg_reg(2'd2, {12'h000, rows[r].en});
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  // raises seg_v, the row loop drops it a cycle later
  task automatic start_seg(input int r);
    @(posedge clk);
    seg_v   <= 1'b1;
    seg     <= '{rows[r].hdr, rows[r].src_ip, rows[r].dst_ip, rows[r].payload_len,
                 payload_sum(rows[r])};
    opt_pkt <= pkts[r];
  endtask

  task automatic send_spurious();
    repeat (4) @(posedge clk);
    seg_v   <= 1'b1;
    seg     <= '1; // junk that must not reach the stream
    opt_pkt <= '1;
    @(posedge clk);
    seg_v   <= 1'b0;
    seg     <= '0;
    opt_pkt <= '0;
  endtask

  task automatic receive_seg(input int r, input int max_bytes);
    int    n;
    byte_t chs_hi;
    n = exp_q.size();
    @(negedge clk);
    while (!tx_sof) begin
      check_flag(tx_v, 1'b0, $sformatf("row %0d tx_v before sof", r));
      check_flag(busy, 1'b1, $sformatf("row %0d busy before sof", r));
      @(negedge clk);
    end
    for (int i = 0; i < max_bytes; i++) begin
      if (i > 0) @(negedge clk);
      check_flag(tx_v, 1'b1, $sformatf("row %0d tx_v at byte %0d", r, i));
      check_flag(busy, 1'b1, $sformatf("row %0d busy at byte %0d", r, i));
      check_flag(tx_sof, i == 0, $sformatf("row %0d tx_sof at byte %0d", r, i));
      check_flag(tx_eof, i == n - 1, $sformatf("row %0d tx_eof at byte %0d", r, i));
      check_byte(tx_d, exp_q[i], $sformatf("row %0d byte %0d", r, i));
      if (i == 16) chs_hi = tx_d;
      if (i == 17) check_chsum({chs_hi, tx_d}, exp_chsum, r);
    end
  endtask

  task automatic abort_with_reset(input int r);
    receive_seg(r, 6); // a few header bytes, then pull reset
    @(posedge clk);
    fsm_rst <= 1'b1;
    repeat (2) @(posedge clk);
    fsm_rst <= 1'b0;
    @(negedge clk);
    check_flag(tx_v, 1'b0, "tx_v after mid-segment reset");
    check_flag(busy, 1'b0, "busy after mid-segment reset");
    check_flag(tx_eof, 1'b0, "tx_eof after mid-segment reset");
  endtask

  initial begin
    void'($urandom(SEED));
    fsm_rst    = 1'b1;
    seg_v      = 1'b0;
    seg        = '0;
    opt_pkt    = '0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_data   = '0;
    ram_we     = 1'b0;
    ram_addr   = '0;
    ram_data   = '0;
    byte_errs  = 0;
    chsum_errs = 0;
    flag_errs  = 0;
    load_table();
    make_random();

    repeat (8) @(posedge clk);
    fsm_rst <= 1'b0;
    @(negedge clk);
    check_flag(tx_v, 1'b0, "tx_v after reset");
    check_flag(tx_sof, 1'b0, "tx_sof after reset");
    check_flag(tx_eof, 1'b0, "tx_eof after reset");
    check_flag(busy, 1'b0, "busy after reset");

    fill_ram();
    write_cfg(0);
    start_seg(0);

    for (int r = 0; r < N_ROWS; r++) begin
      build_expected(r);
      @(posedge clk);
      seg_v   <= 1'b0;
      seg     <= '0;
      opt_pkt <= '0;
      if (rows[r].spur) send_spurious();
      // config is latched at seg_v, so the next row can be set up now
      if (r + 1 < N_ROWS && rows[r + 1].b2b) write_cfg(r + 1);
      if (rows[r].mid_rst) begin
        abort_with_reset(r);
      end else begin
        receive_seg(r, exp_q.size());
      end
      if (r + 1 < N_ROWS && rows[r + 1].b2b) start_seg(r + 1);
      @(negedge clk);
      check_flag(busy, 1'b0, $sformatf("row %0d busy in the cycle after eof", r));
      if (r + 1 < N_ROWS && !rows[r + 1].b2b) begin
        write_cfg(r + 1);
        start_seg(r + 1);
      end
    end

    repeat (4) @(negedge clk);
    check_flag(tx_v, 1'b0, "tx_v after the last segment");
    $display("errors: %0d byte, %0d checksum, %0d flag", byte_errs, chsum_errs, flag_errs);
    if (byte_errs + chsum_errs + flag_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
tcp_tx_pkg.sv
tcp_tx_cfg.sv
tcp_opt_assembler.sv
tcp_chsum_calc.sv
tcp_hdr_serializer.sv
tcp_payload_ram.sv
tcp_tx_top.sv
tb_tcp_tx.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_tcp_tx
RTL_TOP   ?= tcp_tx_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
